//--- rv_isa_pkg.sv
/* RV32I encodings for the register and immediate ALU instructions.
   Imported by the decode and execute logic of the core. */
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Selects SUB over ADD and SRA over SRL
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    // Same word seen as R-type or I-type
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } rv_instr_u;

endpackage

//--- core_pipe_pkg.sv
/* Lane count, PC width and the records that move between issue, execute,
   retire and the register file. */
package core_pipe_pkg;

    import rv_isa_pkg::*;

    localparam int NUM_LANES = 2;
    localparam int PC_WIDTH  = 32;

    // Issued instruction with its operands already read
    typedef struct packed {
        logic                  valid;
        logic [PC_WIDTH-1:0]   pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       a;
        logic [XLEN-1:0]       b;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
    } issue_slot_t;

    typedef struct packed {
        logic                  valid;
        logic [PC_WIDTH-1:0]   pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       result;
    } lane_result_t;

    // Visible completion record, wen low for x0 and non-writing ops
    typedef struct packed {
        logic                  valid;
        logic [PC_WIDTH-1:0]   pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  wen;
        logic [XLEN-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic                  wen;
        logic [REG_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } rf_write_t;

endpackage

//--- reg_file.sv
/* Integer register file, four combinational reads and two writes per cycle.
   Reads see a write to the same register in the same cycle. */
module reg_file (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0]       raddr [2*core_pipe_pkg::NUM_LANES],
    output logic [rv_isa_pkg::XLEN-1:0]             rdata [2*core_pipe_pkg::NUM_LANES],
    input  core_pipe_pkg::rf_write_t                wr    [core_pipe_pkg::NUM_LANES]
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Later port wins, so the younger lane lands last
            for (int w = 0; w < NUM_LANES; w++) begin
                if (wr[w].wen && wr[w].addr != '0) begin
                    regs[wr[w].addr] <= wr[w].data;
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2 * NUM_LANES; p++) begin
            rdata[p] = '0;
            if (raddr[p] != '0) begin
                rdata[p] = regs[raddr[p]];
                for (int w = 0; w < NUM_LANES; w++) begin
                    if (wr[w].wen && wr[w].addr == raddr[p]) begin
                        rdata[p] = wr[w].data;
                    end
                end
            end
        end
    end

    // Retire filters x0 before it reaches here
    a_no_x0_write_0: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr[0].wen && wr[0].addr == '0));
    a_no_x0_write_1: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr[1].wen && wr[1].addr == '0));

endmodule

//--- issue_unit.sv
/* Fetches an aligned instruction pair, decodes it, checks for hazards and
   registers up to two issue slots per cycle. Lane 0 always holds the older one. */
module issue_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    output logic [core_pipe_pkg::PC_WIDTH-1:0]  imem_addr,
    input  logic [rv_isa_pkg::ILEN-1:0]         imem_data_0,
    input  logic [rv_isa_pkg::ILEN-1:0]         imem_data_1,
    input  logic                                imem_ready,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   rf_raddr [2*core_pipe_pkg::NUM_LANES],
    input  logic [rv_isa_pkg::XLEN-1:0]         rf_rdata [2*core_pipe_pkg::NUM_LANES],
    output core_pipe_pkg::issue_slot_t          slots    [core_pipe_pkg::NUM_LANES]
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    typedef struct packed {
        logic                  known;
        alu_op_e               op;
        logic                  use_rs1;
        logic                  use_rs2;
        logic                  is_imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
    } dec_t;

    logic [PC_WIDTH-1:0]  pc_q;
    rv_instr_u            word      [NUM_LANES];
    dec_t                 dec       [NUM_LANES];
    logic [NUM_LANES-1:0] stall_hit;
    logic                 pair_dep;
    logic [NUM_LANES-1:0] issue;
    issue_slot_t          slot_d    [NUM_LANES];

    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        case (funct3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    function automatic dec_t decode(input rv_instr_u w);
        dec_t d;
        d        = '0;
        d.op     = ALU_ADD;
        d.rs1    = w.r.rs1;
        d.rs2    = w.r.rs2;
        d.rd     = w.r.rd;
        d.imm    = {{(XLEN-12){w.i.imm[11]}}, w.i.imm};
        case (w.r.opcode)
            OPC_OP: begin
                d.known   = 1'b1;
                d.use_rs1 = 1'b1;
                d.use_rs2 = 1'b1;
                d.op      = alu_sel(w.r.funct3, w.r.funct7 == FUNCT7_ALT);
            end
            OPC_OP_IMM: begin
                d.known   = 1'b1;
                d.use_rs1 = 1'b1;
                d.is_imm  = 1'b1;
                // Only SRAI carries the alternate bit, ADDI has a plain immediate there
                d.op      = alu_sel(w.i.funct3, w.i.funct3 == F3_SRL_SRA && w.i.imm[10]);
            end
            default: ;
        endcase
        return d;
    endfunction

    // Source still waiting in a slot register, one cycle before bypass can serve it
    function automatic logic in_slot(input logic [REG_ADDR_W-1:0] src);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (slots[l].valid && slots[l].wen && slots[l].rd == src && src != '0) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign word[0]   = imem_data_0;
    assign word[1]   = imem_data_1;
    assign imem_addr = pc_q;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            dec[l]             = decode(word[l]);
            rf_raddr[2*l]      = dec[l].rs1;
            rf_raddr[2*l+1]    = dec[l].rs2;
            stall_hit[l]       = (dec[l].use_rs1 && in_slot(dec[l].rs1)) ||
                                 (dec[l].use_rs2 && in_slot(dec[l].rs2));
        end

        pair_dep = dec[0].known && dec[0].rd != '0 &&
                   ((dec[1].use_rs1 && dec[1].rs1 == dec[0].rd) ||
                    (dec[1].use_rs2 && dec[1].rs2 == dec[0].rd));

        issue[0] = imem_ready && !stall_hit[0];
        issue[1] = issue[0] && !pair_dep && !stall_hit[1];

        for (int l = 0; l < NUM_LANES; l++) begin
            slot_d[l].valid  = issue[l];
            slot_d[l].pc     = pc_q + PC_WIDTH'(4 * l);
            slot_d[l].alu_op = dec[l].op;
            slot_d[l].a      = rf_rdata[2*l];
            slot_d[l].b      = dec[l].is_imm ? dec[l].imm : rf_rdata[2*l+1];
            slot_d[l].rd     = dec[l].rd;
            slot_d[l].wen    = dec[l].known;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= '0;
            for (int l = 0; l < NUM_LANES; l++) begin
                slots[l] <= '0;
            end
        end else begin
            if (issue[1]) begin
                pc_q <= pc_q + PC_WIDTH'(8);
            end else if (issue[0]) begin
                pc_q <= pc_q + PC_WIDTH'(4);
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                slots[l] <= slot_d[l];
            end
        end
    end

    a_slot_order: assert property (@(posedge clk) disable iff (!rst_n)
        slots[1].valid |-> slots[0].valid);

endmodule

//--- alu_lane.sv
/* One integer execution lane. Computes the slot's ALU operation and
   registers the result with its destination for retirement. */
module alu_lane (
    input  logic                         clk,
    input  logic                         rst_n,
    input  core_pipe_pkg::issue_slot_t   slot,
    output core_pipe_pkg::lane_result_t  result
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;

    always_comb begin
        // Shift amount comes from the low bits of either register or immediate
        shamt = slot.b[4:0];
        case (slot.alu_op)
            ALU_ADD:  alu_res = slot.a + slot.b;
            ALU_SUB:  alu_res = slot.a - slot.b;
            ALU_SLL:  alu_res = slot.a << shamt;
            ALU_SLT:  alu_res = XLEN'($signed(slot.a) < $signed(slot.b));
            ALU_SLTU: alu_res = XLEN'(slot.a < slot.b);
            ALU_XOR:  alu_res = slot.a ^ slot.b;
            ALU_SRL:  alu_res = slot.a >> shamt;
            ALU_SRA:  alu_res = $signed(slot.a) >>> shamt;
            ALU_OR:   alu_res = slot.a | slot.b;
            ALU_AND:  alu_res = slot.a & slot.b;
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid  <= slot.valid;
            result.pc     <= slot.pc;
            result.rd     <= slot.rd;
            result.wen    <= slot.wen;
            result.result <= alu_res;
        end
    end

endmodule

//--- retire_unit.sv
/* Turns the registered lane results into register file writes and the
   retire records, in lane order. Purely combinational. */
module retire_unit (
    input  core_pipe_pkg::lane_result_t  results [core_pipe_pkg::NUM_LANES],
    output core_pipe_pkg::rf_write_t     rf_wr   [core_pipe_pkg::NUM_LANES],
    output core_pipe_pkg::retire_t       retire  [core_pipe_pkg::NUM_LANES]
);
    import core_pipe_pkg::*;

    logic [NUM_LANES-1:0] writes;

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            // x0 and non-writing opcodes never reach the register file
            writes[l] = results[l].valid && results[l].wen && results[l].rd != '0;

            rf_wr[l].wen  = writes[l];
            rf_wr[l].addr = results[l].rd;
            rf_wr[l].data = results[l].result;

            retire[l].valid = results[l].valid;
            retire[l].pc    = results[l].pc;
            retire[l].rd    = results[l].rd;
            retire[l].wen   = writes[l];
            retire[l].data  = results[l].result;
        end
    end

    // Issue never fills lane 1 alone, and both lanes advance together
    always_comb begin
        assert final (!results[1].valid || results[0].valid)
            else $error("lane 1 retiring without lane 0");
    end

endmodule

//--- riscv_core.sv
/* Dual-issue integer core top level. Joins the issue unit, the two ALU lanes,
   retirement and the register file, and exposes the retire records. */
module riscv_core (
    input  logic                                clk,
    input  logic                                rst_n,

    // Instruction memory, pair of words at imem_addr and imem_addr+4
    output logic [core_pipe_pkg::PC_WIDTH-1:0]  imem_addr,
    input  logic [rv_isa_pkg::ILEN-1:0]         imem_data_0,
    input  logic [rv_isa_pkg::ILEN-1:0]         imem_data_1,
    input  logic                                imem_ready,

    output core_pipe_pkg::retire_t              retire [core_pipe_pkg::NUM_LANES]
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    issue_slot_t           slots    [NUM_LANES];
    lane_result_t          results  [NUM_LANES];
    rf_write_t             rf_wr    [NUM_LANES];
    logic [REG_ADDR_W-1:0] rf_raddr [2*NUM_LANES];
    logic [XLEN-1:0]       rf_rdata [2*NUM_LANES];

    issue_unit u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_data_0 (imem_data_0),
        .imem_data_1 (imem_data_1),
        .imem_ready  (imem_ready),
        .rf_raddr    (rf_raddr),
        .rf_rdata    (rf_rdata),
        .slots       (slots)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        alu_lane u_lane (
            .clk    (clk),
            .rst_n  (rst_n),
            .slot   (slots[l]),
            .result (results[l])
        );
    end

    retire_unit u_retire (
        .results (results),
        .rf_wr   (rf_wr),
        .retire  (retire)
    );

    reg_file u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .wr    (rf_wr)
    );

endmodule

//--- tb_program.svh
/* Program table for the core testbench. Row k is the instruction at byte
   address 4k with its expected destination, write enable and result. */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int NUM_ROWS = 35;

function automatic row_t program_row(input int k);
    case (k)
        // Seed registers
        0:  return make_row(enc_i(FN_ADD, 1, 0, 100), 1, 1, 32'h0000_0064);
        1:  return make_row(enc_i(FN_ADD, 2, 0, -7), 2, 1, 32'hffff_fff9);
        2:  return make_row(enc_i(FN_ADD, 3, 0, 3), 3, 1, 32'h0000_0003);
        3:  return make_row(enc_i(FN_XOR, 4, 0, -1), 4, 1, 32'hffff_ffff);
        // Register-register operations, one of each
        4:  return make_row(enc_r(FN_ADD, 0, 5, 1, 2), 5, 1, 32'h0000_005d);
        5:  return make_row(enc_r(FN_ADD, 1, 6, 1, 2), 6, 1, 32'h0000_006b);
        6:  return make_row(enc_r(FN_SLL, 0, 7, 1, 3), 7, 1, 32'h0000_0320);
        7:  return make_row(enc_r(FN_SLT, 0, 8, 2, 1), 8, 1, 32'h0000_0001);
        8:  return make_row(enc_r(FN_SLTU, 0, 9, 2, 1), 9, 1, 32'h0000_0000);
        9:  return make_row(enc_r(FN_XOR, 0, 10, 1, 2), 10, 1, 32'hffff_ff9d);
        10: return make_row(enc_r(FN_SR, 0, 11, 2, 3), 11, 1, 32'h1fff_ffff);
        11: return make_row(enc_r(FN_SR, 1, 12, 2, 3), 12, 1, 32'hffff_ffff);
        12: return make_row(enc_r(FN_OR, 0, 13, 1, 3), 13, 1, 32'h0000_0067);
        13: return make_row(enc_r(FN_AND, 0, 14, 1, 2), 14, 1, 32'h0000_0060);
        // Immediate forms
        14: return make_row(enc_i(FN_ADD, 15, 2, 20), 15, 1, 32'h0000_000d);
        15: return make_row(enc_i(FN_SLT, 16, 2, -6), 16, 1, 32'h0000_0001);
        16: return make_row(enc_i(FN_SLTU, 17, 1, -1), 17, 1, 32'h0000_0001);
        17: return make_row(enc_i(FN_XOR, 18, 1, 'h0f), 18, 1, 32'h0000_006b);
        18: return make_row(enc_i(FN_OR, 19, 1, 'h703), 19, 1, 32'h0000_0767);
        19: return make_row(enc_i(FN_AND, 20, 2, 'h0f0), 20, 1, 32'h0000_00f0);
        20: return make_row(enc_i(FN_SLL, 21, 1, 4), 21, 1, 32'h0000_0640);
        21: return make_row(enc_i(FN_SR, 22, 4, 28), 22, 1, 32'h0000_000f);
        // SRAI, the arithmetic flag is bit 10 of the immediate
        22: return make_row(enc_i(FN_SR, 23, 2, 'h401), 23, 1, 32'hffff_fffc);
        // Chain where each instruction reads the one before
        23: return make_row(enc_i(FN_ADD, 24, 1, 1), 24, 1, 32'h0000_0065);
        24: return make_row(enc_r(FN_ADD, 0, 25, 24, 24), 25, 1, 32'h0000_00ca);
        25: return make_row(enc_r(FN_ADD, 1, 26, 25, 1), 26, 1, 32'h0000_0066);
        26: return make_row(enc_i(FN_SLL, 27, 26, 2), 27, 1, 32'h0000_0198);
        // x0 is never written
        27: return make_row(enc_i(FN_ADD, 0, 1, 55), 0, 0, 32'h0000_009b);
        28: return make_row(enc_r(FN_ADD, 0, 30, 0, 3), 30, 1, 32'h0000_0003);
        // Three writes to x31, so two adjacent ones share a fetch pair
        29: return make_row(enc_i(FN_ADD, 31, 0, 17), 31, 1, 32'h0000_0011);
        30: return make_row(enc_i(FN_ADD, 31, 0, 34), 31, 1, 32'h0000_0022);
        31: return make_row(enc_i(FN_ADD, 31, 0, 51), 31, 1, 32'h0000_0033);
        32: return make_row(enc_r(FN_ADD, 0, 6, 31, 31), 6, 1, 32'h0000_0066);
        // LUI x7 is not a kept opcode and leaves x7 alone
        33: return make_row(32'h1234_53b7, 7, 0, 32'h0000_0000);
        34: return make_row(enc_i(FN_ADD, 8, 7, 0), 8, 1, 32'h0000_0320);
        default: return make_row(NOP_WORD, 0, 0, 32'h0000_0000);
    endcase
endfunction

`endif

//--- tb_riscv_core.sv
/* Testbench for the dual-issue core. Runs the program table with random
   instruction memory gaps and checks every retire record in program order. */
module tb_riscv_core;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pipe_pkg::*;

    localparam int          CLK_PERIOD   = 10;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] LFSR_SEED    = 32'h59d1_c391;
    localparam logic [6:0]  OPC_ALU_R    = 7'b0110011;
    localparam logic [6:0]  OPC_ALU_I    = 7'b0010011;
    localparam logic [31:0] NOP_WORD     = 32'h0000_0013;

    // funct3, shared by the register and immediate forms
    localparam int FN_ADD  = 0;
    localparam int FN_SLL  = 1;
    localparam int FN_SLT  = 2;
    localparam int FN_SLTU = 3;
    localparam int FN_XOR  = 4;
    localparam int FN_SR   = 5;
    localparam int FN_OR   = 6;
    localparam int FN_AND  = 7;

    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] value;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        imem_ready;
    logic [31:0] imem_addr;
    logic [31:0] imem_data_0;
    logic [31:0] imem_data_1;
    retire_t     retire [NUM_LANES];
    logic [31:0] lfsr_state = LFSR_SEED;
    int          errors = 0;
    int          checks = 0;
    int          next_row = 0;

    // alt selects SUB or SRA
    function automatic logic [31:0] enc_r(input int f3, input int alt, input int rd,
                                          input int rs1, input int rs2);
        return {(alt != 0) ? 7'h20 : 7'h00, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OPC_ALU_R};
    endfunction

    function automatic logic [31:0] enc_i(input int f3, input int rd, input int rs1,
                                          input int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), OPC_ALU_I};
    endfunction

    function automatic row_t make_row(input logic [31:0] word, input int rd, input int wen,
                                      input logic [31:0] value);
        row_t r;
        r.instr = word;
        r.rd    = 5'(rd);
        r.wen   = (wen != 0);
        r.value = value;
        return r;
    endfunction

    `include "tb_program.svh"

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        row_t r;
        r = program_row(int'(addr >> 2));
        return r.instr;
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail at %0t ns: row %0d %s is %h, expected %h",
                     $time, next_row, what, got, want);
        end
    endtask

    task automatic check_idle(input string when);
        checks++;
        if (retire[0].valid || retire[1].valid) begin
            errors++;
            $display("Fail at %0t ns: retire record valid %s", $time, when);
        end
        if (imem_addr !== 32'h0) begin
            errors++;
            $display("Fail at %0t ns: imem_addr is %h %s, expected 0", $time, imem_addr, when);
        end
    endtask

    task automatic check_retire_pair();
        row_t want;
        if (retire[1].valid && !retire[0].valid) begin
            errors++;
            $display("Lane 1 retired without lane 0 at %0t ns", $time);
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            if (retire[l].valid && next_row < NUM_ROWS) begin
                want = program_row(next_row);
                expect_equal("pc", retire[l].pc, 32'(4 * next_row));
                expect_equal("rd", 32'(retire[l].rd), 32'(want.rd));
                expect_equal("wen", 32'(retire[l].wen), 32'(want.wen));
                // Only the ALU opcodes have a defined result
                if (want.instr[6:0] == OPC_ALU_R || want.instr[6:0] == OPC_ALU_I) begin
                    expect_equal("data", retire[l].data, want.value);
                end
                next_row++;
            end
        end
    endtask

    always #(CLK_PERIOD / 2) clk = ~clk;

    riscv_core riscv_core_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_addr   (imem_addr),
        .imem_data_0 (imem_data_0),
        .imem_data_1 (imem_data_1),
        .imem_ready  (imem_ready),
        .retire      (retire)
    );

    // Instruction memory answers in the same cycle
    always_comb begin
        imem_data_0 = fetch_word(imem_addr);
        imem_data_1 = fetch_word(imem_addr + 32'd4);
    end

    // Ready is low when both drawn bits are set
    initial begin : ready_driver
        logic gap_a;
        logic gap_b;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            lfsr_state = lfsr_next(lfsr_state);
            gap_a      = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
            gap_b      = lfsr_state[0];
            imem_ready <= !(gap_a && gap_b);
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RESET_CYCLES + NUM_ROWS * 8 + 100));
        $display("Timeout: retirement stalled with %0d of %0d rows retired",
                 next_row, NUM_ROWS);
        $display("Checks: %0d, errors: %0d, rows retired: %0d of %0d",
                 checks, errors, next_row, NUM_ROWS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : main
        rst_n      = 1'b0;
        imem_ready = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_idle("during reset");
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");

        while (next_row < NUM_ROWS) begin
            @(negedge clk);
            check_retire_pair();
        end

        $display("Checks: %0d, errors: %0d, rows retired: %0d of %0d",
                 checks, errors, next_row, NUM_ROWS);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
rv_isa_pkg.sv
core_pipe_pkg.sv
reg_file.sv
issue_unit.sv
alu_lane.sv
retire_unit.sv
riscv_core.sv
tb_riscv_core.sv

//--- run.sh
#!/bin/sh
# Builds the core and its testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_riscv_core -f sim.f -o tb_riscv_core_sim > build.log 2>&1 &&
./obj_dir/tb_riscv_core_sim > sim.log 2>&1 &&
grep -q "ALL TESTS PASSED" sim.log &&
echo "PASS: see sim.log" ||
{ echo "FAIL: see build.log and sim.log"; exit 1; }
